/* all.f */
+incdir+verification
logic/load_op_pkg.sv
logic/dcache_addr_pkg.sv
logic/load_req_fsm.sv
logic/load_data_align.sv
logic/load_unit.sv
verification/load_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the load unit testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module load_unit_tb -o load_unit_sim \
    && ./obj_dir/load_unit_sim | tee /dev/stderr | grep -qF "All tests passed!" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verification/load_unit_vectors.svh */
// load unit test vectors, one row per load with its stimulus timing and expected result
`ifndef LOAD_UNIT_VECTORS_SVH
`define LOAD_UNIT_VECTORS_SVH

// columns: op, vaddr, paddr, grant delay, tlb miss cycles, store match cycles,
// flush flag, random data flag, rdata, expected result
typedef struct packed {
    load_op_e    op;
    logic [63:0] vaddr;
    logic [63:0] paddr;
    int          gnt_delay;
    int          tlb_miss;
    int          store_match;
    logic        flush;
    logic        rand_data;
    logic [63:0] rdata;
    logic [63:0] expected;
} vector_t;

// in DATA_A only the top byte is negative, in DATA_B every byte is
localparam logic [63:0] DATA_A  = 64'h8877_6655_4433_2211;
localparam logic [63:0] DATA_B  = 64'hf0e1_d2c3_b4a5_9687;
localparam logic [63:0] PADDR_A = 64'h00ab_cdef_0123_4000;
localparam logic [63:0] PADDR_B = 64'hff80_0000_0000_1000;

localparam int NUM_VECTORS = 38;

localparam vector_t VECTORS [NUM_VECTORS] = '{
    // every opcode at each aligned offset
    '{LD,  64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h8877_6655_4433_2211},
    '{LW,  64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_4433_2211},
    '{LW,  64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'hffff_ffff_8877_6655},
    '{LWU, 64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_b4a5_9687},
    '{LWU, 64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_f0e1_d2c3},
    '{LH,  64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_9687},
    '{LH,  64'h4a32, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_4433},
    '{LH,  64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_d2c3},
    '{LH,  64'h4a36, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'hffff_ffff_ffff_8877},
    '{LHU, 64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_9687},
    '{LHU, 64'h4a32, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_b4a5},
    '{LHU, 64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_6655},
    '{LHU, 64'h4a36, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_f0e1},
    '{LB,  64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0011},
    '{LB,  64'h4a31, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_ff96},
    '{LB,  64'h4a32, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0033},
    '{LB,  64'h4a33, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_ffb4},
    '{LB,  64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0055},
    '{LB,  64'h4a35, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_ffd2},
    '{LB,  64'h4a36, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0077},
    '{LB,  64'h4a37, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'hffff_ffff_ffff_ff88},
    '{LBU, 64'h4a30, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_0087},
    '{LBU, 64'h4a31, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0022},
    '{LBU, 64'h4a32, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_00a5},
    '{LBU, 64'h4a33, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0044},
    '{LBU, 64'h4a34, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_00c3},
    '{LBU, 64'h4a35, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0066},
    '{LBU, 64'h4a36, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_00e1},
    '{LBU, 64'h4a37, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_00f0},
    // handshake corner cases
    '{LW,  64'h5b14, PADDR_A, 3, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_f0e1_d2c3},
    '{LHU, 64'h5b12, PADDR_A, 0, 0, 3, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_4433},
    '{LB,  64'h5b15, PADDR_A, 0, 2, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0066},
    '{LBU, 64'h6c23, PADDR_A, 2, 1, 0, 1'b0, 1'b0, DATA_B, 64'h0000_0000_0000_00b4},
    '{LD,  64'h6c28, PADDR_A, 0, 0, 0, 1'b1, 1'b0, DATA_A, 64'h0000_0000_0000_0000},
    '{LH,  64'h6c2e, PADDR_A, 0, 0, 0, 1'b0, 1'b0, DATA_B, 64'hffff_ffff_ffff_f0e1},
    '{LBU, 64'h7fff, PADDR_B, 0, 0, 0, 1'b0, 1'b0, DATA_A, 64'h0000_0000_0000_0088},
    // rdata and expected result are filled in by the testbench
    '{LW,  64'h7a34, PADDR_A, 1, 0, 0, 1'b0, 1'b1, DATA_A, 64'h0000_0000_0000_0000},
    '{LH,  64'h7a36, PADDR_A, 0, 0, 1, 1'b0, 1'b1, DATA_A, 64'h0000_0000_0000_0000}
};

string vector_names [NUM_VECTORS] = '{
    "ld_off0", "lw_off0", "lw_off4", "lwu_off0", "lwu_off4",
    "lh_off0", "lh_off2", "lh_off4", "lh_off6",
    "lhu_off0", "lhu_off2", "lhu_off4", "lhu_off6",
    "lb_off0", "lb_off1", "lb_off2", "lb_off3", "lb_off4", "lb_off5", "lb_off6", "lb_off7",
    "lbu_off0", "lbu_off1", "lbu_off2", "lbu_off3", "lbu_off4", "lbu_off5", "lbu_off6",
    "lbu_off7",
    "grant_delay", "store_stall", "tlb_miss", "tlb_miss_grant_delay",
    "flush_in_tag", "after_flush", "tag_high_bits", "random_lw", "random_lh"
};

`endif

/* verification/load_unit_tb.sv */
// testbench for the load unit, runs table loads against TLB, store check and cache models
`timescale 1ns/1ps
`default_nettype none

module load_unit_tb
    import load_op_pkg::*;
    import dcache_addr_pkg::*;
();

    localparam int TransIdWidth = 3;

    logic                          clk_i = 1'b0;
    logic                          rst_ni;
    logic                          flush_i;
    logic                          valid_i;
    logic [VADDR_WIDTH-1:0]        vaddr_i;
    logic [TransIdWidth-1:0]       trans_id_i;
    load_op_e                      op_i;
    logic                          pop_o;
    logic                          valid_o;
    logic [TransIdWidth-1:0]       trans_id_o;
    logic [DATA_WIDTH-1:0]         result_o;
    logic                          translation_req_o;
    logic [VADDR_WIDTH-1:0]        vaddr_o;
    logic [VADDR_WIDTH-1:0]        paddr_i;
    logic                          dtlb_hit_i;
    logic                          page_offset_match_i;
    logic                          data_req_o;
    logic [DCACHE_INDEX_WIDTH-1:0] address_index_o;
    logic [DCACHE_TAG_WIDTH-1:0]   address_tag_o;
    xfer_size_e                    data_size_o;
    logic                          tag_valid_o;
    logic                          kill_req_o;
    logic                          data_gnt_i;
    logic                          data_rvalid_i = 1'b0;
    logic [DATA_WIDTH-1:0]         data_rdata_i;

    logic [31:0] lcg_state = 32'ha63e4de8;
    logic        tag_pending;
    int          error_count = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    `include "load_unit_vectors.svh"

    load_unit #(
        .TransIdWidth (TransIdWidth)
    ) i_load_unit (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .vaddr_i             (vaddr_i),
        .trans_id_i          (trans_id_i),
        .op_i                (op_i),
        .pop_o               (pop_o),
        .valid_o             (valid_o),
        .trans_id_o          (trans_id_o),
        .result_o            (result_o),
        .translation_req_o   (translation_req_o),
        .vaddr_o             (vaddr_o),
        .paddr_i             (paddr_i),
        .dtlb_hit_i          (dtlb_hit_i),
        .page_offset_match_i (page_offset_match_i),
        .data_req_o          (data_req_o),
        .address_index_o     (address_index_o),
        .address_tag_o       (address_tag_o),
        .data_size_o         (data_size_o),
        .tag_valid_o         (tag_valid_o),
        .kill_req_o          (kill_req_o),
        .data_gnt_i          (data_gnt_i),
        .data_rvalid_i       (data_rvalid_i),
        .data_rdata_i        (data_rdata_i)
    );

    always #50 clk_i = ~clk_i;

    // the cache model answers a tag that is not killed one cycle later
    always begin
        @(negedge clk_i);
        tag_pending = tag_valid_o && !kill_req_o;
        @(posedge clk_i);
        #1;
        data_rvalid_i = tag_pending;
    end

    // ------------------------------------------------------------
    // reference helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // number of bytes a load of this kind reads
    function automatic int access_bytes(input load_op_e op);
        case (op)
            LD:      return 8;
            LW, LWU: return 4;
            LH, LHU: return 2;
            default: return 1;
        endcase
    endfunction

    // cache transfer size that covers the given number of bytes
    function automatic xfer_size_e size_for_bytes(input int nbytes);
        case (nbytes)
            8:       return SIZE_DOUBLE;
            4:       return SIZE_WORD;
            2:       return SIZE_HALF;
            default: return SIZE_BYTE;
        endcase
    endfunction

    // picks the addressed bytes one by one and extends the top one
    function automatic logic [63:0] expected_load(input load_op_e op, input int offset,
                                                  input logic [63:0] data);
        int          nbytes;
        logic        sext;
        logic [63:0] res;
        nbytes = access_bytes(op);
        sext   = (op == LW) || (op == LH) || (op == LB);
        res    = '0;
        for (int b = 0; b < nbytes; b++) begin
            if (offset + b < 8) begin
                res[8*b +: 8] = data[8*(offset + b) +: 8];
            end
        end
        if (sext && res[8*nbytes-1]) begin
            for (int b = nbytes; b < 8; b++) begin
                res[8*b +: 8] = 8'hff;
            end
        end
        return res;
    endfunction

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s: %s expected %h, got %h", test_name, what, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // one table row driven a cycle at a time
    // ------------------------------------------------------------
    task automatic run_vector(input int n);
        vector_t     v;
        string       name;
        logic [63:0] data;
        logic [63:0] exp;
        xfer_size_e  exp_size;
        int          cyc;
        int          req_seen;
        int          kill_cyc;
        int          flush_at;
        int          pops;
        int          valids;
        int          kills;
        int          exp_kills;
        int          bad;
        int          errs_before;
        logic        req_waiting;
        logic        done;

        v           = VECTORS[n];
        name        = vector_names[n];
        data        = v.rdata;
        exp         = v.expected;
        exp_size    = size_for_bytes(access_bytes(v.op));
        errs_before = error_count;
        if (v.rand_data) begin
            data = {lcg_next(), lcg_next()};
            exp  = expected_load(v.op, int'(v.vaddr[2:0]), data);
        end

        // the issuer holds the load until it sees pop_o
        valid_i      = 1'b1;
        vaddr_i      = v.vaddr;
        paddr_i      = v.paddr;
        op_i         = v.op;
        trans_id_i   = n[TransIdWidth-1:0];
        data_rdata_i = data;

        cyc         = 0;
        req_seen    = 0;
        kill_cyc    = -1;
        flush_at    = -1;
        pops        = 0;
        valids      = 0;
        kills       = 0;
        bad         = 0;
        req_waiting = 1'b0;
        done        = 1'b0;
        while (!done) begin
            // grant after the delay and report TLB misses until the retry window has passed
            page_offset_match_i = (cyc < v.store_match);
            data_gnt_i          = (req_seen >= v.gnt_delay);
            dtlb_hit_i          = (v.tlb_miss == 0) ||
                                  (kill_cyc >= 0 && cyc > kill_cyc + v.tlb_miss);
            flush_i             = (cyc == flush_at);

            @(negedge clk_i);
            if (translation_req_o) begin
                check_value(name, "vaddr to TLB", v.vaddr, vaddr_o);
            end
            if (data_req_o) begin
                req_seen++;
                check_value(name, "data size", 64'(exp_size), 64'(data_size_o));
            end
            // a request that was not granted has to stay up in the next cycle
            if (req_waiting && !data_req_o) begin
                bad++;
            end
            req_waiting = data_req_o && !data_gnt_i;
            // no cache request may leave while a store to the same offset is pending
            if (data_req_o && page_offset_match_i) begin
                bad++;
            end
            // a withheld grant keeps translation up and the load in the queue
            if (data_req_o && !data_gnt_i && (pop_o || !translation_req_o)) begin
                bad++;
            end
            if (pop_o) begin
                pops++;
                if (v.flush) begin
                    flush_at = cyc + 1;
                end
            end
            if (kill_req_o) begin
                kills++;
                if (kill_cyc < 0) begin
                    kill_cyc = cyc;
                end
                // the cache only sees a kill together with the tag strobe
                if (!tag_valid_o) begin
                    bad++;
                end
            end
            if (tag_valid_o && !kill_req_o) begin
                check_value(name, "address tag", 64'(v.paddr[55:12]), 64'(address_tag_o));
                check_value(name, "address index", 64'(v.vaddr[11:0]), 64'(address_index_o));
            end
            if (valid_o) begin
                valids++;
                check_value(name, "result", exp, result_o);
                check_value(name, "trans id", 64'(n[TransIdWidth-1:0]), 64'(trans_id_o));
            end
            done = v.flush ? (flush_at >= 0 && cyc >= flush_at + 3) : (valids > 0);

            @(posedge clk_i);
            #1;
            if (pops > 0) begin
                valid_i = 1'b0;
            end
            cyc++;
        end
        flush_i = 1'b0;

        exp_kills = 0;
        if (v.tlb_miss > 0) begin
            exp_kills++;
        end
        if (v.flush) begin
            exp_kills++;
        end
        check_value(name, "pop count", 64'd1, 64'(pops));
        check_value(name, "valid count", v.flush ? 64'd0 : 64'd1, 64'(valids));
        check_value(name, "kill count", 64'(exp_kills), 64'(kills));
        check_value(name, "handshake violations", 64'd0, 64'(bad));

        if (error_count == errs_before) begin
            pass_count++;
            $display("[PASS] %s", name);
        end else begin
            fail_count++;
            $display("[DONE] %s with %0d mismatches", name, error_count - errs_before);
        end
    endtask

    initial begin
        rst_ni              = 1'b0;
        flush_i             = 1'b0;
        valid_i             = 1'b0;
        vaddr_i             = '0;
        trans_id_i          = '0;
        op_i                = LD;
        paddr_i             = '0;
        dtlb_hit_i          = 1'b0;
        page_offset_match_i = 1'b0;
        data_gnt_i          = 1'b0;
        data_rdata_i        = '0;

        @(negedge clk_i);
        check_value("reset", "control outputs", 64'd0,
                    64'({pop_o, valid_o, data_req_o, tag_valid_o, kill_req_o, translation_req_o}));
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int n = 0; n < NUM_VECTORS; n++) begin
            run_vector(n);
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // the slowest row takes well under 40 cycles
    initial begin
        repeat (NUM_VECTORS * 40 + 10) @(posedge clk_i);
        $display("watchdog expired, the load unit stopped answering before all rows ran");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* logic/load_unit.sv */
// load unit top level, joins the request control with the response aligner
`timescale 1ns/1ps
`default_nettype none

module load_unit
    import load_op_pkg::*;
    import dcache_addr_pkg::*;
#(
    parameter int unsigned TransIdWidth = 3
) (
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire logic                          flush_i,
    // issue queue
    input  wire logic                          valid_i,
    input  wire logic [VADDR_WIDTH-1:0]        vaddr_i,
    input  wire logic [TransIdWidth-1:0]       trans_id_i,
    input  wire load_op_e                      op_i,
    output logic                               pop_o,
    // writeback
    output logic                               valid_o,
    output logic [TransIdWidth-1:0]            trans_id_o,
    output logic [DATA_WIDTH-1:0]              result_o,
    // data TLB
    output logic                               translation_req_o,
    output logic [VADDR_WIDTH-1:0]             vaddr_o,
    input  wire logic [VADDR_WIDTH-1:0]        paddr_i,
    input  wire logic                          dtlb_hit_i,
    // store address check
    input  wire logic                          page_offset_match_i,
    // data cache read port
    output logic                               data_req_o,
    output logic [DCACHE_INDEX_WIDTH-1:0]      address_index_o,
    output logic [DCACHE_TAG_WIDTH-1:0]        address_tag_o,
    output xfer_size_e                         data_size_o,
    output logic                               tag_valid_o,
    output logic                               kill_req_o,
    input  wire logic                          data_gnt_i,
    input  wire logic                          data_rvalid_i,
    input  wire logic [DATA_WIDTH-1:0]         data_rdata_i
);

    logic capture;
    logic retire_ok;

    // the TLB and the store checker both look at the untranslated address
    assign vaddr_o = vaddr_i;

    // the index comes from the page offset and the tag from the translation
    assign address_index_o = vaddr_i[DCACHE_INDEX_WIDTH-1:0];
    assign address_tag_o   = paddr_i[DCACHE_TAG_WIDTH+DCACHE_INDEX_WIDTH-1:DCACHE_INDEX_WIDTH];

    load_req_fsm i_load_req_fsm (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .valid_i             (valid_i),
        .op_i                (op_i),
        .pop_o               (pop_o),
        .dtlb_hit_i          (dtlb_hit_i),
        .page_offset_match_i (page_offset_match_i),
        .translation_req_o   (translation_req_o),
        .data_gnt_i          (data_gnt_i),
        .data_req_o          (data_req_o),
        .data_size_o         (data_size_o),
        .tag_valid_o         (tag_valid_o),
        .kill_req_o          (kill_req_o),
        .capture_o           (capture),
        .retire_ok_o         (retire_ok)
    );

    load_data_align #(
        .TransIdWidth (TransIdWidth)
    ) i_load_data_align (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .capture_i     (capture),
        .trans_id_i    (trans_id_i),
        .offset_i      (vaddr_i[OFFSET_BITS-1:0]),
        .op_i          (op_i),
        .data_rvalid_i (data_rvalid_i),
        .data_rdata_i  (data_rdata_i),
        .retire_ok_i   (retire_ok),
        .valid_o       (valid_o),
        .trans_id_o    (trans_id_o),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

/* logic/load_data_align.sv */
// response side of the load unit, realigns returned data and extends it to the result
`timescale 1ns/1ps
`default_nettype none

module load_data_align
    import load_op_pkg::*;
#(
    parameter int unsigned TransIdWidth = 3
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    // metadata of the load that is being issued
    input  wire logic                    capture_i,
    input  wire logic [TransIdWidth-1:0] trans_id_i,
    input  wire logic [OFFSET_BITS-1:0]  offset_i,
    input  wire load_op_e                op_i,
    // returned cache data
    input  wire logic                    data_rvalid_i,
    input  wire logic [DATA_WIDTH-1:0]   data_rdata_i,
    input  wire logic                    retire_ok_i,
    // retired result
    output logic                         valid_o,
    output logic [TransIdWidth-1:0]      trans_id_o,
    output logic [DATA_WIDTH-1:0]        result_o
);

    localparam int unsigned NumBytes = DATA_WIDTH / 8;

    logic [TransIdWidth-1:0] trans_id_q;
    logic [OFFSET_BITS-1:0]  offset_q;
    load_op_e                op_q;
    logic                    signed_d, signed_q;
    logic [OFFSET_BITS-1:0]  idx_d, idx_q;
    logic [DATA_WIDTH-1:0]   shifted_data;
    logic [NumBytes-1:0]     sign_bits;
    logic                    sign_bit;

    // work out the sign byte while the load is still in flight
    assign signed_d = (op_i == LW) || (op_i == LH) || (op_i == LB);
    assign idx_d    = (op_i == LW || op_i == LWU) ? offset_i + 3'd3 :
                      (op_i == LH || op_i == LHU) ? offset_i + 3'd1 :
                                                    offset_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            trans_id_q <= '0;
            offset_q   <= '0;
            op_q       <= LD;
            signed_q   <= 1'b0;
            idx_q      <= '0;
        end else if (capture_i) begin
            trans_id_q <= trans_id_i;
            offset_q   <= offset_i;
            op_q       <= op_i;
            signed_q   <= signed_d;
            idx_q      <= idx_d;
        end
    end

    // ------------------------------------------------------------
    // realignment and extension
    // ------------------------------------------------------------

    // move the addressed byte down to bit 0
    assign shifted_data = data_rdata_i >> {offset_q, 3'b000};

    // top bit of every byte, picked in parallel with the shifter
    always_comb begin
        for (int i = 0; i < NumBytes; i++) begin
            sign_bits[i] = data_rdata_i[8*i+7];
        end
    end

    // unsigned loads fill with zeros
    assign sign_bit = signed_q & sign_bits[idx_q];

    always_comb begin
        case (op_q)
            LW, LWU: result_o = {{(DATA_WIDTH-32){sign_bit}}, shifted_data[31:0]};
            LH, LHU: result_o = {{(DATA_WIDTH-16){sign_bit}}, shifted_data[15:0]};
            LB, LBU: result_o = {{(DATA_WIDTH-8){sign_bit}}, shifted_data[7:0]};
            default: result_o = shifted_data;
        endcase
    end

    // only data for a live request is retired
    assign valid_o    = data_rvalid_i & retire_ok_i;
    assign trans_id_o = trans_id_q;

endmodule

`default_nettype wire

/* logic/load_req_fsm.sv */
// request-side control of the load unit, drives translation, cache handshake and retire gating
`timescale 1ns/1ps
`default_nettype none

module load_req_fsm
    import load_op_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_ni,
    input  wire logic       flush_i,
    // issue side
    input  wire logic       valid_i,
    input  wire load_op_e   op_i,
    output logic            pop_o,
    // translation and store check
    input  wire logic       dtlb_hit_i,
    input  wire logic       page_offset_match_i,
    output logic            translation_req_o,
    // data cache request side
    input  wire logic       data_gnt_i,
    output logic            data_req_o,
    output xfer_size_e      data_size_o,
    output logic            tag_valid_o,
    output logic            kill_req_o,
    // towards the aligner
    output logic            capture_o,
    output logic            retire_ok_o
);

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GNT,
        SEND_TAG,
        WAIT_PAGE_OFFSET,
        ABORT_TRANSACTION,
        WAIT_TRANSLATION,
        WAIT_FLUSH
    } load_state_e;

    load_state_e state_d, state_q;

    // the size only depends on the opcode and is qualified by data_req_o
    assign data_size_o = xfer_size_of(op_i);

    // ------------------------------------------------------------
    // next state and handshake outputs
    // ------------------------------------------------------------
    always_comb begin
        state_d           = state_q;
        translation_req_o = 1'b0;
        data_req_o        = 1'b0;
        tag_valid_o       = 1'b0;
        kill_req_o        = 1'b0;
        pop_o             = 1'b0;

        case (state_q)
            IDLE: begin
                // nothing pending, a new load is handled below
            end

            // the store buffer still holds a store to the same page offset
            WAIT_PAGE_OFFSET: begin
                if (!page_offset_match_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // keep both requests up until the cache arbiter grants us
            WAIT_GNT: begin
                translation_req_o = 1'b1;
                data_req_o        = 1'b1;
                if (data_gnt_i) begin
                    if (dtlb_hit_i) begin
                        state_d = SEND_TAG;
                        pop_o   = 1'b1;
                    end else begin
                        state_d = ABORT_TRANSACTION;
                    end
                end
            end

            // the granted index is followed by the translated tag
            SEND_TAG: begin
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            // a TLB miss frees the cache port so the page walker can use it
            ABORT_TRANSACTION: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = WAIT_TRANSLATION;
            end

            // hold the translation request until the TLB has the entry
            WAIT_TRANSLATION: begin
                translation_req_o = 1'b1;
                if (dtlb_hit_i) begin
                    state_d = WAIT_GNT;
                end
            end

            // cancel whatever the cache still has in flight for us
            WAIT_FLUSH: begin
                kill_req_o  = 1'b1;
                tag_valid_o = 1'b1;
                state_d     = IDLE;
            end

            default: begin
                state_d = IDLE;
            end
        endcase

        // a new load may start when idle and also while the previous tag goes out
        if ((state_q == IDLE || state_q == SEND_TAG) && valid_i) begin
            // translation starts before the store check settles to ease timing
            translation_req_o = 1'b1;
            if (page_offset_match_i) begin
                state_d = WAIT_PAGE_OFFSET;
            end else begin
                data_req_o = 1'b1;
                if (!data_gnt_i) begin
                    state_d = WAIT_GNT;
                end else if (dtlb_hit_i) begin
                    state_d = SEND_TAG;
                    pop_o   = 1'b1;
                end else begin
                    state_d = ABORT_TRANSACTION;
                end
            end
        end

        // a flush always spends one cycle killing the outstanding request
        if (flush_i) begin
            state_d = WAIT_FLUSH;
        end
    end

    // the aligner latches the load metadata exactly when it leaves the queue
    assign capture_o = pop_o;

    // data coming back while we kill or flush belongs to a dead request
    assign retire_ok_o = (state_q != WAIT_FLUSH) && !kill_req_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_addr_pkg.sv */
// address split between data cache index, cache tag and virtual address
`default_nettype none

package dcache_addr_pkg;

    // ------------------------------------------------------------
    // address widths
    // ------------------------------------------------------------

    // virtual and physical addresses share one width in this core
    localparam int unsigned VADDR_WIDTH = 64;

    // ------------------------------------------------------------
    // cache address split
    // ------------------------------------------------------------

    // the index lies inside the page offset, so it comes straight
    // from the virtual address before translation has finished
    localparam int unsigned DCACHE_INDEX_WIDTH = 12;

    // the tag sits directly above the index in the physical address
    // and is only sent in the cycle after the index was granted
    localparam int unsigned DCACHE_TAG_WIDTH = 44;

    // index plus tag never reach past the top of the address
    // so the tag slice is always legal

endpackage

`default_nettype wire

/* logic/load_op_pkg.sv */
// load operation types shared by the load unit and its testbench
`default_nettype none

package load_op_pkg;

    // width of the data returned by the cache and of the load result
    localparam int unsigned DATA_WIDTH = 64;

    // byte offset of a load inside one doubleword
    localparam int unsigned OFFSET_BITS = 3;

    // load opcodes handled by the unit, the U variants zero-extend
    typedef enum logic [3:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU
    } load_op_e;

    // transfer size as presented to the data cache
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } xfer_size_e;

    // map an opcode onto the number of bytes the cache has to fetch
    function automatic xfer_size_e xfer_size_of(input load_op_e op);
        case (op)
            LD:       return SIZE_DOUBLE;
            LW, LWU:  return SIZE_WORD;
            LH, LHU:  return SIZE_HALF;
            default:  return SIZE_BYTE;
        endcase
    endfunction

endpackage

`default_nettype wire
